// File: source/dq_decode_pkg.sv
package dq_decode_pkg;

	//////////////////////////////////////////////////
	// field widths
	//////////////////////////////////////////////////

	localparam int LANES = 2;	// instructions per bundle

	localparam int INSTR_WIDTH = 32;
	localparam int OPC_WIDTH = 6;	// primary opcode in bits 0-5
	localparam int XO_WIDTH = 3;	// DQ extended opcode in bits 29-31
	localparam int REG_WIDTH = 5;
	localparam int USE_WIDTH = 2;
	localparam int DISP_WIDTH = 12;	// DQ field in bits 16-27
	localparam int UNIT_WIDTH = 3;

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	// instruction word numbered the ISA way so bit 0 is the msb
	typedef logic [0:INSTR_WIDTH-1] instr_t;

	typedef logic [REG_WIDTH-1:0] reg_idx_t;
	typedef logic [USE_WIDTH-1:0] reg_use_t;
	typedef logic [DISP_WIDTH-1:0] disp_t;
	typedef logic [UNIT_WIDTH-1:0] unit_code_t;

	//////////////////////////////////////////////////
	// opcodes
	//////////////////////////////////////////////////

	localparam logic [OPC_WIDTH-1:0] OPC_LQ = 6'd56;	// load quadword
	localparam logic [OPC_WIDTH-1:0] OPC_DQ_VSX = 6'd61;	// lxv / stxv share this one

	localparam logic [XO_WIDTH-1:0] XO_LXV = 3'd1;
	localparam logic [XO_WIDTH-1:0] XO_STXV = 3'd2;

	//////////////////////////////////////////////////
	// register use codes
	//////////////////////////////////////////////////

	// says what the later stages do with a register field
	localparam reg_use_t USE_NONE = 2'd0;
	localparam reg_use_t USE_READ = 2'd1;
	localparam reg_use_t USE_WRITE = 2'd2;
	localparam reg_use_t USE_READ_WRITE = 2'd3;

	//////////////////////////////////////////////////
	// functional unit codes
	//////////////////////////////////////////////////

	localparam unit_code_t UNIT_FX = 3'd0;	// also the idle code
	localparam unit_code_t UNIT_FP = 3'd1;
	localparam unit_code_t UNIT_LDST = 3'd2;
	localparam unit_code_t UNIT_BRANCH = 3'd3;
	localparam unit_code_t UNIT_TRAP = 3'd4;	// illegal forms end up here

endpackage

// File: source/bundle_unpack.sv
module bundle_unpack
(
	input logic clock_i,
	input logic rst_n_i,

	// bundle from fetch with lane 0 oldest
	input logic [dq_decode_pkg::LANES-1:0] bundle_valid_i,
	input dq_decode_pkg::instr_t [dq_decode_pkg::LANES-1:0] bundle_instr_i,

	// one word per lane decoder
	output logic [dq_decode_pkg::LANES-1:0] lane_valid_o,
	output dq_decode_pkg::instr_t [dq_decode_pkg::LANES-1:0] lane_instr_o
);

	genvar lane;

	//////////////////////////////////////////////////
	// per-lane input registers
	//////////////////////////////////////////////////

	for (lane = 0; lane < dq_decode_pkg::LANES; lane++)
	begin : g_lane

		// valid strobe cleared by reset
		always_ff @(posedge clock_i)
		begin
			if (!rst_n_i)
			begin
				lane_valid_o[lane] <= 1'b0;
			end
			else
			begin
				lane_valid_o[lane] <= bundle_valid_i[lane];
			end
		end

		// word only loads when its lane carries something
		// an idle lane keeps its old word
		always_ff @(posedge clock_i)
		begin
			if (bundle_valid_i[lane])
			begin
				lane_instr_o[lane] <= bundle_instr_i[lane];
			end
		end

	end

endmodule

// File: source/dq_lane_decoder.sv
module dq_lane_decoder
(
	input logic clock_i,
	input logic rst_n_i,

	input logic valid_i,
	input dq_decode_pkg::instr_t instr_i,

	output logic valid_o,	// instruction recognised
	output dq_decode_pkg::reg_idx_t reg1_o,
	output dq_decode_pkg::reg_idx_t reg2_o,
	output dq_decode_pkg::reg_use_t reg1_use_o,
	output dq_decode_pkg::reg_use_t reg2_use_o,
	output logic reg1_vsx_o,	// reg1 sits in the vsx file
	output dq_decode_pkg::disp_t disp_o,
	output logic tx_o,
	output dq_decode_pkg::unit_code_t unit_o
);

	logic [dq_decode_pkg::OPC_WIDTH-1:0] opcode;
	logic [dq_decode_pkg::XO_WIDTH-1:0] xo;
	dq_decode_pkg::reg_idx_t rt;
	dq_decode_pkg::reg_idx_t ra;

	logic recog;
	dq_decode_pkg::reg_use_t rt_use;
	dq_decode_pkg::reg_use_t ra_use;
	logic rt_vsx;
	logic tx;
	dq_decode_pkg::unit_code_t unit;

	// DQ form fields
	assign opcode = instr_i[0:5];
	assign rt = instr_i[6:10];
	assign ra = instr_i[11:15];
	assign xo = instr_i[29:31];

	//////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////

	always_comb
	begin
		recog = 1'b0;
		rt_use = dq_decode_pkg::USE_NONE;
		ra_use = dq_decode_pkg::USE_NONE;
		rt_vsx = 1'b0;
		tx = 1'b0;
		unit = dq_decode_pkg::UNIT_FX;
		if (valid_i)
		begin
			case (opcode)
				dq_decode_pkg::OPC_LQ:
				begin
					recog = 1'b1;
					rt_use = dq_decode_pkg::USE_WRITE;	// gpr pair rt, rt+1
					ra_use = dq_decode_pkg::USE_READ;
					// odd target or target equal to the base is an illegal form
					if (rt[0] || (rt == ra))
						unit = dq_decode_pkg::UNIT_TRAP;
					else
						unit = dq_decode_pkg::UNIT_LDST;
				end
				dq_decode_pkg::OPC_DQ_VSX:
				begin
					case (xo)
						dq_decode_pkg::XO_LXV:
						begin
							recog = 1'b1;
							rt_use = dq_decode_pkg::USE_WRITE;
							ra_use = dq_decode_pkg::USE_READ;
							rt_vsx = 1'b1;
							tx = instr_i[28];
							unit = dq_decode_pkg::UNIT_LDST;
						end
						dq_decode_pkg::XO_STXV:
						begin
							recog = 1'b1;
							rt_use = dq_decode_pkg::USE_READ;	// store source
							ra_use = dq_decode_pkg::USE_READ;
							rt_vsx = 1'b1;
							tx = instr_i[28];	// sx for the store
							unit = dq_decode_pkg::UNIT_LDST;
						end
						default:
						begin
							recog = 1'b0;	// other xo values not handled here
						end
					endcase
				end
				default:
				begin
					recog = 1'b0;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		if (!rst_n_i)
		begin
			valid_o <= 1'b0;
			reg1_use_o <= dq_decode_pkg::USE_NONE;
			reg2_use_o <= dq_decode_pkg::USE_NONE;
			unit_o <= dq_decode_pkg::UNIT_FX;
		end
		else
		begin
			valid_o <= recog;
			reg1_use_o <= rt_use;
			reg2_use_o <= ra_use;
			unit_o <= unit;
		end
	end

	always_ff @(posedge clock_i)
	begin
		reg1_o <= rt;
		reg2_o <= ra;
		reg1_vsx_o <= rt_vsx;
		disp_o <= instr_i[16:27];
		tx_o <= tx;
	end

endmodule

// File: source/dispatch_merge.sv
module dispatch_merge
(
	input logic clock_i,
	input logic rst_n_i,

	// decoded lanes with lane 0 first in program order
	input logic [dq_decode_pkg::LANES-1:0] dec_valid_i,
	input dq_decode_pkg::reg_idx_t [dq_decode_pkg::LANES-1:0] dec_reg1_i,
	input dq_decode_pkg::reg_idx_t [dq_decode_pkg::LANES-1:0] dec_reg2_i,
	input dq_decode_pkg::reg_use_t [dq_decode_pkg::LANES-1:0] dec_reg1_use_i,
	input dq_decode_pkg::reg_use_t [dq_decode_pkg::LANES-1:0] dec_reg2_use_i,
	input logic [dq_decode_pkg::LANES-1:0] dec_reg1_vsx_i,
	input dq_decode_pkg::disp_t [dq_decode_pkg::LANES-1:0] dec_disp_i,
	input logic [dq_decode_pkg::LANES-1:0] dec_tx_i,
	input dq_decode_pkg::unit_code_t [dq_decode_pkg::LANES-1:0] dec_unit_i,

	output dq_decode_pkg::reg_idx_t [dq_decode_pkg::LANES-1:0] reg1_o,
	output dq_decode_pkg::reg_idx_t [dq_decode_pkg::LANES-1:0] reg2_o,
	output dq_decode_pkg::reg_use_t [dq_decode_pkg::LANES-1:0] reg1_use_o,
	output dq_decode_pkg::reg_use_t [dq_decode_pkg::LANES-1:0] reg2_use_o,
	output dq_decode_pkg::disp_t [dq_decode_pkg::LANES-1:0] disp_o,
	output logic [dq_decode_pkg::LANES-1:0] tx_o,
	output dq_decode_pkg::unit_code_t [dq_decode_pkg::LANES-1:0] unit_o,
	output logic [dq_decode_pkg::LANES-1:0] dispatch_o,
	output logic stall_o
);

	logic [dq_decode_pkg::LANES-1:0] dep;	// lane reads an earlier lane's write
	logic [dq_decode_pkg::LANES-1:0] dispatch_d;
	logic stall_d;

	function automatic logic is_read(input dq_decode_pkg::reg_use_t use_code);
		return (use_code == dq_decode_pkg::USE_READ) ||
			(use_code == dq_decode_pkg::USE_READ_WRITE);
	endfunction

	function automatic logic is_write(input dq_decode_pkg::reg_use_t use_code);
		return (use_code == dq_decode_pkg::USE_WRITE) ||
			(use_code == dq_decode_pkg::USE_READ_WRITE);
	endfunction

	//////////////////////////////////////////////////
	// read after write inside the bundle
	//////////////////////////////////////////////////

	always_comb
	begin
		dep = '0;
		for (int i = 1; i < dq_decode_pkg::LANES; i++)
		begin
			for (int j = 0; j < i; j++)
			begin
				// older lane j must be live, write its reg1 and share the tx bit
				if (dec_valid_i[j] && is_write(dec_reg1_use_i[j]) &&
					(dec_tx_i[j] == dec_tx_i[i]))
				begin
					// reg2 is always a gpr base
					if (is_read(dec_reg2_use_i[i]) && !dec_reg1_vsx_i[j] &&
						(dec_reg2_i[i] == dec_reg1_i[j]))
						dep[i] = 1'b1;
					// vsx source against vsx target
					if (is_read(dec_reg1_use_i[i]) && dec_reg1_vsx_i[i] &&
						dec_reg1_vsx_i[j] && (dec_reg1_i[i] == dec_reg1_i[j]))
						dep[i] = 1'b1;
				end
			end
		end
	end

	// once a live lane is held every younger lane waits too
	always_comb
	begin
		logic blocked;
		blocked = 1'b0;
		for (int i = 0; i < dq_decode_pkg::LANES; i++)
		begin
			dispatch_d[i] = dec_valid_i[i] && !dep[i] && !blocked;
			if (dec_valid_i[i] && !dispatch_d[i])
				blocked = 1'b1;
		end
	end

	assign stall_d = |(dec_valid_i & ~dispatch_d);

	//////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		if (!rst_n_i)
		begin
			dispatch_o <= '0;
			stall_o <= 1'b0;
			reg1_use_o <= {dq_decode_pkg::LANES{dq_decode_pkg::USE_NONE}};
			reg2_use_o <= {dq_decode_pkg::LANES{dq_decode_pkg::USE_NONE}};
			unit_o <= {dq_decode_pkg::LANES{dq_decode_pkg::UNIT_FX}};
		end
		else
		begin
			dispatch_o <= dispatch_d;
			stall_o <= stall_d;
			reg1_use_o <= dec_reg1_use_i;
			reg2_use_o <= dec_reg2_use_i;
			unit_o <= dec_unit_i;	// trap lanes pass through unchanged
		end
	end

	always_ff @(posedge clock_i)
	begin
		reg1_o <= dec_reg1_i;
		reg2_o <= dec_reg2_i;
		disp_o <= dec_disp_i;
		tx_o <= dec_tx_i;
	end

endmodule

// File: source/dq_decode_top.sv
module dq_decode_top
(
	input logic clock_i,
	input logic rst_n_i,

	input logic [dq_decode_pkg::LANES-1:0] bundle_valid_i,
	input dq_decode_pkg::instr_t [dq_decode_pkg::LANES-1:0] bundle_instr_i,

	output dq_decode_pkg::reg_idx_t [dq_decode_pkg::LANES-1:0] reg1_o,
	output dq_decode_pkg::reg_idx_t [dq_decode_pkg::LANES-1:0] reg2_o,
	output dq_decode_pkg::reg_use_t [dq_decode_pkg::LANES-1:0] reg1_use_o,
	output dq_decode_pkg::reg_use_t [dq_decode_pkg::LANES-1:0] reg2_use_o,
	output dq_decode_pkg::disp_t [dq_decode_pkg::LANES-1:0] disp_o,
	output logic [dq_decode_pkg::LANES-1:0] tx_o,
	output dq_decode_pkg::unit_code_t [dq_decode_pkg::LANES-1:0] unit_o,
	output logic [dq_decode_pkg::LANES-1:0] dispatch_o,
	output logic stall_o
);

	genvar lane;

	// unpack to decoders
	logic [dq_decode_pkg::LANES-1:0] lane_valid;
	dq_decode_pkg::instr_t [dq_decode_pkg::LANES-1:0] lane_instr;

	// decoders to merger
	logic [dq_decode_pkg::LANES-1:0] dec_valid;
	dq_decode_pkg::reg_idx_t [dq_decode_pkg::LANES-1:0] dec_reg1;
	dq_decode_pkg::reg_idx_t [dq_decode_pkg::LANES-1:0] dec_reg2;
	dq_decode_pkg::reg_use_t [dq_decode_pkg::LANES-1:0] dec_reg1_use;
	dq_decode_pkg::reg_use_t [dq_decode_pkg::LANES-1:0] dec_reg2_use;
	logic [dq_decode_pkg::LANES-1:0] dec_reg1_vsx;
	dq_decode_pkg::disp_t [dq_decode_pkg::LANES-1:0] dec_disp;
	logic [dq_decode_pkg::LANES-1:0] dec_tx;
	dq_decode_pkg::unit_code_t [dq_decode_pkg::LANES-1:0] dec_unit;

	bundle_unpack bundle_unpack_inst
	(
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.bundle_valid_i(bundle_valid_i),
		.bundle_instr_i(bundle_instr_i),
		.lane_valid_o(lane_valid),
		.lane_instr_o(lane_instr)
	);

	//////////////////////////////////////////////////
	// one decoder per lane
	//////////////////////////////////////////////////

	for (lane = 0; lane < dq_decode_pkg::LANES; lane++)
	begin : g_lane
		dq_lane_decoder dq_lane_decoder_inst
		(
			.clock_i(clock_i),
			.rst_n_i(rst_n_i),
			.valid_i(lane_valid[lane]),
			.instr_i(lane_instr[lane]),
			.valid_o(dec_valid[lane]),
			.reg1_o(dec_reg1[lane]),
			.reg2_o(dec_reg2[lane]),
			.reg1_use_o(dec_reg1_use[lane]),
			.reg2_use_o(dec_reg2_use[lane]),
			.reg1_vsx_o(dec_reg1_vsx[lane]),
			.disp_o(dec_disp[lane]),
			.tx_o(dec_tx[lane]),
			.unit_o(dec_unit[lane])
		);
	end

	dispatch_merge dispatch_merge_inst
	(
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.dec_valid_i(dec_valid),
		.dec_reg1_i(dec_reg1),
		.dec_reg2_i(dec_reg2),
		.dec_reg1_use_i(dec_reg1_use),
		.dec_reg2_use_i(dec_reg2_use),
		.dec_reg1_vsx_i(dec_reg1_vsx),
		.dec_disp_i(dec_disp),
		.dec_tx_i(dec_tx),
		.dec_unit_i(dec_unit),
		.reg1_o(reg1_o),
		.reg2_o(reg2_o),
		.reg1_use_o(reg1_use_o),
		.reg2_use_o(reg2_use_o),
		.disp_o(disp_o),
		.tx_o(tx_o),
		.unit_o(unit_o),
		.dispatch_o(dispatch_o),
		.stall_o(stall_o)
	);

endmodule

// File: test/dq_decode_checks.svh
`ifndef DQ_DECODE_CHECKS_SVH
`define DQ_DECODE_CHECKS_SVH

//////////////////////////////////////////////////
// compare tasks for the DUT outputs
//////////////////////////////////////////////////

task automatic check_reg(input dq_decode_pkg::reg_idx_t got, exp, input string what);
	if (got !== exp)
	begin
		$display("[ERROR] %0t: %s is r%0d, expected r%0d", $time, what, got, exp);
		case_errors++;
		total_errors++;
	end
endtask

task automatic check_use(input dq_decode_pkg::reg_use_t got, exp, input string what);
	if (got !== exp)
	begin
		$display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
		case_errors++;
		total_errors++;
	end
endtask

task automatic check_unit(input dq_decode_pkg::unit_code_t got, exp, input string what);
	if (got !== exp)
	begin
		$display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
		case_errors++;
		total_errors++;
	end
endtask

task automatic check_disp(input dq_decode_pkg::disp_t got, exp, input string what);
	if (got !== exp)
	begin
		$display("[ERROR] %0t: %s is %03h, expected %03h", $time, what, got, exp);
		case_errors++;
		total_errors++;
	end
endtask

// per-lane masks such as dispatch
task automatic check_mask(input logic [dq_decode_pkg::LANES-1:0] got, exp, input string what);
	if (got !== exp)
	begin
		$display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
		case_errors++;
		total_errors++;
	end
endtask

task automatic check_bit(input logic got, exp, input string what);	// tx and stall
	if (got !== exp)
	begin
		$display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
		case_errors++;
		total_errors++;
	end
endtask

`endif

// File: test/dq_decode_tb.sv
module dq_decode_tb;

	logic clock_i = 1'b0;
	logic rst_n_i;
	logic [dq_decode_pkg::LANES-1:0] bundle_valid_i;
	dq_decode_pkg::instr_t [dq_decode_pkg::LANES-1:0] bundle_instr_i;

	dq_decode_pkg::reg_idx_t [dq_decode_pkg::LANES-1:0] reg1_o;
	dq_decode_pkg::reg_idx_t [dq_decode_pkg::LANES-1:0] reg2_o;
	dq_decode_pkg::reg_use_t [dq_decode_pkg::LANES-1:0] reg1_use_o;
	dq_decode_pkg::reg_use_t [dq_decode_pkg::LANES-1:0] reg2_use_o;
	dq_decode_pkg::disp_t [dq_decode_pkg::LANES-1:0] disp_o;
	logic [dq_decode_pkg::LANES-1:0] tx_o;
	dq_decode_pkg::unit_code_t [dq_decode_pkg::LANES-1:0] unit_o;
	logic [dq_decode_pkg::LANES-1:0] dispatch_o;
	logic stall_o;

	// one entry per line of the case file
	logic [dq_decode_pkg::LANES-1:0] valid_q [$];
	dq_decode_pkg::instr_t [dq_decode_pkg::LANES-1:0] instr_q [$];
	dq_decode_pkg::reg_idx_t [dq_decode_pkg::LANES-1:0] reg1_q [$];
	dq_decode_pkg::reg_idx_t [dq_decode_pkg::LANES-1:0] reg2_q [$];
	dq_decode_pkg::reg_use_t [dq_decode_pkg::LANES-1:0] use1_q [$];
	dq_decode_pkg::reg_use_t [dq_decode_pkg::LANES-1:0] use2_q [$];
	dq_decode_pkg::disp_t [dq_decode_pkg::LANES-1:0] disp_q [$];
	logic [dq_decode_pkg::LANES-1:0] tx_q [$];
	dq_decode_pkg::unit_code_t [dq_decode_pkg::LANES-1:0] unit_q [$];
	logic [dq_decode_pkg::LANES-1:0] dispatch_q [$];
	logic stall_q [$];

	int pending_idx [$];	// cases in flight
	int pending_stamp [$];	// cycle count when each went in
	int cycle_cnt = 0;
	int num_cases = 0;
	int checked_cnt = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int case_errors = 0;
	int total_errors = 0;
	bit cases_loaded = 1'b0;

	`include "dq_decode_checks.svh"

	dq_decode_top dq_decode_top_inst
	(
		.clock_i(clock_i),
		.rst_n_i(rst_n_i),
		.bundle_valid_i(bundle_valid_i),
		.bundle_instr_i(bundle_instr_i),
		.reg1_o(reg1_o),
		.reg2_o(reg2_o),
		.reg1_use_o(reg1_use_o),
		.reg2_use_o(reg2_use_o),
		.disp_o(disp_o),
		.tx_o(tx_o),
		.unit_o(unit_o),
		.dispatch_o(dispatch_o),
		.stall_o(stall_o)
	);

	always #5 clock_i = ~clock_i;

	always @(posedge clock_i)
	begin
		cycle_cnt <= cycle_cnt + 1;
	end

	//////////////////////////////////////////////////
	// case file
	//////////////////////////////////////////////////

	task automatic load_cases();
		int fd;
		int cnt;
		int base;
		string line;
		logic [31:0] f [19];
		dq_decode_pkg::instr_t [dq_decode_pkg::LANES-1:0] instr;
		dq_decode_pkg::reg_idx_t [dq_decode_pkg::LANES-1:0] r1;
		dq_decode_pkg::reg_idx_t [dq_decode_pkg::LANES-1:0] r2;
		dq_decode_pkg::reg_use_t [dq_decode_pkg::LANES-1:0] u1;
		dq_decode_pkg::reg_use_t [dq_decode_pkg::LANES-1:0] u2;
		dq_decode_pkg::disp_t [dq_decode_pkg::LANES-1:0] disp;
		logic [dq_decode_pkg::LANES-1:0] tx;
		dq_decode_pkg::unit_code_t [dq_decode_pkg::LANES-1:0] unit;
		fd = $fopen("test/dq_decode_cases.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the case file test/dq_decode_cases.txt");
			total_errors++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line.getc(0) == "#")
				continue;
			cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
				f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
			if (cnt == 19)
			begin
				for (int l = 0; l < dq_decode_pkg::LANES; l++)
				begin
					base = 1 + dq_decode_pkg::LANES + 7 * l;	// seven fields per lane
					instr[l] = f[1 + l];
					r1[l] = f[base][4:0];
					r2[l] = f[base + 1][4:0];
					u1[l] = f[base + 2][1:0];
					u2[l] = f[base + 3][1:0];
					disp[l] = f[base + 4][11:0];
					tx[l] = f[base + 5][0];
					unit[l] = f[base + 6][2:0];
				end
				valid_q.push_back(f[0][dq_decode_pkg::LANES-1:0]);
				instr_q.push_back(instr);
				reg1_q.push_back(r1);
				reg2_q.push_back(r2);
				use1_q.push_back(u1);
				use2_q.push_back(u2);
				disp_q.push_back(disp);
				tx_q.push_back(tx);
				unit_q.push_back(unit);
				dispatch_q.push_back(f[17][dq_decode_pkg::LANES-1:0]);
				stall_q.push_back(f[18][0]);
			end
			else if (cnt > 0)
			begin
				$display("a line of the case file has %0d fields instead of 19", cnt);
				total_errors++;
			end
		end
		$fclose(fd);
		num_cases = valid_q.size();
		if (num_cases == 0)
		begin
			$display("the case file holds no cases");
			total_errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// output checks
	//////////////////////////////////////////////////

	task automatic check_case(input int idx);
		string tag;
		case_errors = 0;
		for (int l = 0; l < dq_decode_pkg::LANES; l++)
		begin
			tag = $sformatf("case %0d lane %0d", idx, l);
			check_use(reg1_use_o[l], use1_q[idx][l], {tag, " reg1 use"});
			check_use(reg2_use_o[l], use2_q[idx][l], {tag, " reg2 use"});
			check_unit(unit_o[l], unit_q[idx][l], {tag, " unit"});
			// fields only carry meaning on a recognised lane
			if (use1_q[idx][l] != dq_decode_pkg::USE_NONE)
			begin
				check_reg(reg1_o[l], reg1_q[idx][l], {tag, " reg1"});
				check_reg(reg2_o[l], reg2_q[idx][l], {tag, " reg2"});
				check_disp(disp_o[l], disp_q[idx][l], {tag, " displacement"});
				check_bit(tx_o[l], tx_q[idx][l], {tag, " tx"});
			end
		end
		check_mask(dispatch_o, dispatch_q[idx], $sformatf("case %0d dispatch", idx));
		check_bit(stall_o, stall_q[idx], $sformatf("case %0d stall", idx));
		if (case_errors == 0)
		begin
			pass_cnt++;
			$display("case %0d passed", idx);
		end
		else
		begin
			fail_cnt++;
			$display("case %0d failed with %0d mismatches", idx, case_errors);
		end
		checked_cnt++;
	endtask

	// nothing dispatched, nothing stalled, units idle
	task automatic check_idle(input string when);
		for (int l = 0; l < dq_decode_pkg::LANES; l++)
		begin
			check_unit(unit_o[l], dq_decode_pkg::UNIT_FX, $sformatf("%s lane %0d unit", when, l));
		end
		check_mask(dispatch_o, '0, {when, " dispatch"});
		check_bit(stall_o, 1'b0, {when, " stall"});
	endtask

	// each case is due three edges after the edge that drove it
	always @(negedge clock_i)
	begin
		if (pending_idx.size() != 0 && pending_stamp[0] + 4 == cycle_cnt)
		begin
			check_case(pending_idx.pop_front());
			pending_stamp.delete(0);
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	initial
	begin : main
		rst_n_i <= 1'b0;
		bundle_valid_i <= '0;
		bundle_instr_i <= '0;
		load_cases();
		cases_loaded = 1'b1;
		@(posedge clock_i);
		@(negedge clock_i);
		check_idle("during reset");
		@(posedge clock_i);
		rst_n_i <= 1'b1;	// released after two edges
		@(negedge clock_i);
		check_idle("right after reset");
		for (int i = 0; i < num_cases; i++)
		begin
			@(posedge clock_i);
			bundle_valid_i <= valid_q[i];
			bundle_instr_i <= instr_q[i];
			pending_idx.push_back(i);
			pending_stamp.push_back(cycle_cnt);
		end
		@(posedge clock_i);
		bundle_valid_i <= '0;
		while (checked_cnt < num_cases)
		begin
			@(posedge clock_i);
		end
		@(negedge clock_i);
		check_idle("after the last case");
		$display("%0d cases passed, %0d failed, %0d errors in total",
			pass_cnt, fail_cnt, total_errors);
		if (total_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin : watchdog
		wait (cases_loaded);
		#((num_cases + 20) * 10);
		$display("the run timed out with %0d of %0d cases checked", checked_cnt, num_cases);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: test/dq_decode_cases.txt
# valid instr0 instr1, then per lane reg1 reg2 reg1_use reg2_use disp tx unit, then dispatch stall
# all hex, lane 0 first; fields of a lane that decodes nothing are not compared
3 e0850100 e0c70200  04 05 2 1 010 0 2  06 07 2 1 020 0 2  3 0
3 e068abc0 e14a7ff0  03 08 2 1 abc 0 4  0a 0a 2 1 7ff 0 4  3 0
3 f5811239 f6824562  0c 01 2 1 123 1 2  14 02 1 1 456 0 2  3 0
3 f4220105 38600005  00 00 0 0 000 0 0  00 00 0 0 000 0 0  0 0
3 e1010000 f4480401  08 01 2 1 000 0 2  02 08 2 1 040 0 2  1 1
3 f5030081 e1481000  08 03 2 1 008 0 2  0a 08 2 1 100 0 2  3 0
3 f6040209 f605030a  10 04 2 1 020 1 2  10 05 1 1 030 1 2  1 1
3 f6040209 f6050302  10 04 2 1 020 1 2  10 05 1 1 030 0 2  3 0
2 e0850100 e04300c0  00 00 0 0 000 0 0  02 03 2 1 00c 0 2  2 0
1 f7e0fffa e1010000  1f 00 1 1 fff 1 2  00 00 0 0 000 0 0  1 0
0 e0850100 f4480401  00 00 0 0 000 0 0  00 00 0 0 000 0 0  0 0
3 e0a10010 e0c50020  05 01 2 1 001 0 4  06 05 2 1 002 0 2  1 1
3 7c0802a6 f4010001  00 00 0 0 000 0 0  00 01 2 1 000 0 2  2 0
3 f4e90a02 f4e90b01  07 09 1 1 0a0 0 2  07 09 2 1 0b0 0 2  3 0
3 f4400000 e1c23000  00 00 0 0 000 0 0  0e 02 2 1 300 0 2  2 0
3 e3df8000 f7fe5551  1e 1f 2 1 800 0 2  1f 1e 2 1 555 0 2  1 1

// File: flist.f
+incdir+test
source/dq_decode_pkg.sv
source/bundle_unpack.sv
source/dq_lane_decoder.sv
source/dispatch_merge.sv
source/dq_decode_top.sv
test/dq_decode_tb.sv

// File: Makefile
# Verilator build and run for the DQ decode testbench
VERILATOR ?= verilator
TOP ?= dq_decode_tb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing -j 0

SOURCES := $(wildcard source/*.sv test/*.sv test/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides pass or fail
run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
